// File: hw/cbus_pkg.sv
package cbus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus widths.
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;   // one strobe per byte.

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

    // cache bus burst length, beats minus one.
    typedef logic [3:0] mlen_t;

    ////////////////////////////////////////////////////////////////////////////
    // AXI field types.
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;

    localparam axi_size_t AXI_SIZE_8B = 3'd3;   // full 64-bit beat.

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_t;

    // next beat address of a wrapping burst.
    // the block is (len + 1) beats of 8 bytes, aligned to its own size.
    function automatic addr_t wrap_next(addr_t addr, axi_len_t len);
        addr_t mask;
        mask = ((addr_t'(len) + addr_t'(1)) << 3) - addr_t'(1);
        return (addr & ~mask) | ((addr + addr_t'(8)) & mask);
    endfunction

endpackage

// File: hw/cbus_to_axi.sv
module cbus_to_axi
    import cbus_pkg::*;
(
    input  logic       aclk,
    input  logic       areset,

    // cache bus.
    input  logic       creq_valid,
    input  logic       creq_is_write,
    input  addr_t      creq_addr,
    input  axi_size_t  creq_size,
    input  mlen_t      creq_len,
    input  strb_t      creq_strobe,
    input  data_t      creq_data,
    output logic       cresp_ready,
    output logic       cresp_last,
    output data_t      cresp_data,

    // AXI master.
    output addr_t      araddr,
    output axi_len_t   arlen,
    output axi_size_t  arsize,
    output axi_burst_t arburst,
    output logic       arvalid,
    input  logic       arready,
    input  data_t      rdata,
    input  logic       rlast,
    input  logic       rvalid,
    output logic       rready,
    output addr_t      awaddr,
    output axi_len_t   awlen,
    output axi_size_t  awsize,
    output axi_burst_t awburst,
    output logic       awvalid,
    input  logic       awready,
    output data_t      wdata,
    output strb_t      wstrb,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    input  logic       bvalid,
    output logic       bready
);

    // one phase bit per AXI channel.
    localparam int PH_AR = 4;
    localparam int PH_R  = 3;
    localparam int PH_AW = 2;
    localparam int PH_W  = 1;
    localparam int PH_B  = 0;

    logic [4:0] in_issue;
    logic [4:0] next_issue;
    logic [4:0] handshake;
    logic [4:0] ended;
    logic       busy;
    logic       is_last;

    addr_t      saved_addr;
    axi_size_t  saved_size;
    mlen_t      saved_len;
    mlen_t      count;   // beats left after the current one.

    assign next_issue = creq_is_write ? 5'b00111 : 5'b11000;
    assign busy       = |in_issue;
    assign is_last    = (count == '0);

    assign handshake = {
        in_issue[PH_AR] && arready,
        in_issue[PH_R]  && rvalid,
        in_issue[PH_AW] && awready,
        in_issue[PH_W]  && wready,
        in_issue[PH_B]  && bvalid
    };
    assign ended = handshake & {1'b1, rlast, 1'b1, wlast, 1'b1};   // data phases end on last.

    ////////////////////////////////////////////////////////////////////////////
    // cache bus response.
    ////////////////////////////////////////////////////////////////////////////

    assign cresp_ready = handshake[PH_R] || handshake[PH_W];
    assign cresp_last  = cresp_ready && (!in_issue[PH_R] || rlast) && is_last;
    assign cresp_data  = rdata;

    ////////////////////////////////////////////////////////////////////////////
    // AXI channels driven straight from the phases.
    ////////////////////////////////////////////////////////////////////////////

    assign arvalid = in_issue[PH_AR];
    assign araddr  = saved_addr;
    assign arlen   = axi_len_t'(saved_len);
    assign arsize  = saved_size;
    assign arburst = burst_wrap;
    assign rready  = in_issue[PH_R];

    assign awvalid = in_issue[PH_AW];
    assign awaddr  = saved_addr;
    assign awlen   = axi_len_t'(saved_len);
    assign awsize  = saved_size;
    assign awburst = burst_wrap;

    assign wvalid  = in_issue[PH_W];
    assign wdata   = creq_data;     // the controller steps data per beat.
    assign wstrb   = creq_strobe;
    assign wlast   = is_last;
    assign bready  = in_issue[PH_B];

    always_ff @(posedge aclk) begin
        if (!areset) begin
            in_issue <= '0;
        end else if (busy) begin
            in_issue <= in_issue & ~ended;
        end else if (creq_valid) begin
            in_issue <= next_issue;   // one cycle of issue delay.
        end
    end

    // request capture while idle, beat countdown while busy.
    always_ff @(posedge aclk) begin
        if (!busy) begin
            saved_addr <= creq_addr;
            saved_size <= creq_size;
            saved_len  <= creq_len;
            count      <= creq_len;
        end else if (cresp_ready && !cresp_last) begin
            count <= count - mlen_t'(1);
        end
    end

    a_addr_stable: assert property (@(posedge aclk) disable iff (!areset)
        (in_issue[PH_R] || in_issue[PH_W]) |-> creq_addr == saved_addr);

    // the memory's last read beat lines up with the beat counter.
    a_rlast_in_step: assert property (@(posedge aclk) disable iff (!areset)
        handshake[PH_R] |-> rlast == is_last);

endmodule

// File: hw/axi_arbiter.sv
module axi_arbiter
    import cbus_pkg::*;
#(
    parameter int NUM_PORTS = 2
) (
    input  logic                        aclk,
    input  logic                        areset,

    // bridge side.
    input  addr_t      [NUM_PORTS-1:0]  up_araddr,
    input  axi_len_t   [NUM_PORTS-1:0]  up_arlen,
    input  axi_size_t  [NUM_PORTS-1:0]  up_arsize,
    input  axi_burst_t [NUM_PORTS-1:0]  up_arburst,
    input  logic       [NUM_PORTS-1:0]  up_arvalid,
    output logic       [NUM_PORTS-1:0]  up_arready,
    output data_t      [NUM_PORTS-1:0]  up_rdata,
    output logic       [NUM_PORTS-1:0]  up_rlast,
    output logic       [NUM_PORTS-1:0]  up_rvalid,
    input  logic       [NUM_PORTS-1:0]  up_rready,
    input  addr_t      [NUM_PORTS-1:0]  up_awaddr,
    input  axi_len_t   [NUM_PORTS-1:0]  up_awlen,
    input  axi_size_t  [NUM_PORTS-1:0]  up_awsize,
    input  axi_burst_t [NUM_PORTS-1:0]  up_awburst,
    input  logic       [NUM_PORTS-1:0]  up_awvalid,
    output logic       [NUM_PORTS-1:0]  up_awready,
    input  data_t      [NUM_PORTS-1:0]  up_wdata,
    input  strb_t      [NUM_PORTS-1:0]  up_wstrb,
    input  logic       [NUM_PORTS-1:0]  up_wlast,
    input  logic       [NUM_PORTS-1:0]  up_wvalid,
    output logic       [NUM_PORTS-1:0]  up_wready,
    output logic       [NUM_PORTS-1:0]  up_bvalid,
    input  logic       [NUM_PORTS-1:0]  up_bready,

    // memory side.
    output addr_t                       araddr,
    output axi_len_t                    arlen,
    output axi_size_t                   arsize,
    output axi_burst_t                  arburst,
    output logic                        arvalid,
    input  logic                        arready,
    input  data_t                       rdata,
    input  logic                        rlast,
    input  logic                        rvalid,
    output logic                        rready,
    output addr_t                       awaddr,
    output axi_len_t                    awlen,
    output axi_size_t                   awsize,
    output axi_burst_t                  awburst,
    output logic                        awvalid,
    input  logic                        awready,
    output data_t                       wdata,
    output strb_t                       wstrb,
    output logic                        wlast,
    output logic                        wvalid,
    input  logic                        wready,
    input  logic                        bvalid,
    output logic                        bready
);

    localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    typedef logic [IDX_W-1:0] idx_t;
    typedef enum logic [1:0] {arb_idle, arb_read, arb_write} arb_state_t;

    arb_state_t state;
    idx_t       grant;
    idx_t       rr_ptr;   // last port served.
    idx_t       pick;
    logic       pick_valid;

    // first requester after rr_ptr with wraparound.
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick       = rr_ptr;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            idx = (int'(rr_ptr) + i) % NUM_PORTS;
            if (!pick_valid && (up_arvalid[idx] || up_awvalid[idx])) begin
                pick_valid = 1'b1;
                pick       = idx_t'(idx);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!areset) begin
            state  <= arb_idle;
            grant  <= '0;
            rr_ptr <= idx_t'(NUM_PORTS - 1);   // port 0 goes first.
        end else begin
            case (state)
                arb_idle: begin
                    if (pick_valid) begin
                        state <= up_arvalid[pick] ? arb_read : arb_write;
                        grant <= pick;
                    end
                end
                arb_read: begin
                    if (rvalid && rready && rlast) begin
                        state  <= arb_idle;
                        rr_ptr <= grant;
                    end
                end
                default: begin
                    if (bvalid && bready) begin
                        state  <= arb_idle;
                        rr_ptr <= grant;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // channel mux. only the granted bridge sees any ready or valid.
    ////////////////////////////////////////////////////////////////////////////

    assign up_rdata = {NUM_PORTS{rdata}};
    assign up_rlast = {NUM_PORTS{rlast}};

    always_comb begin
        {araddr, arlen, arsize, arvalid, rready} = '0;
        {awaddr, awlen, awsize, awvalid} = '0;
        {wdata, wstrb, wlast, wvalid, bready} = '0;
        arburst    = burst_fixed;
        awburst    = burst_fixed;
        up_arready = '0;
        up_rvalid  = '0;
        up_awready = '0;
        up_wready  = '0;
        up_bvalid  = '0;
        if (state == arb_read) begin
            araddr            = up_araddr[grant];
            arlen             = up_arlen[grant];
            arsize            = up_arsize[grant];
            arburst           = up_arburst[grant];
            arvalid           = up_arvalid[grant];
            rready            = up_rready[grant];
            up_arready[grant] = arready;
            up_rvalid[grant]  = rvalid;
        end
        if (state == arb_write) begin
            awaddr            = up_awaddr[grant];
            awlen             = up_awlen[grant];
            awsize            = up_awsize[grant];
            awburst           = up_awburst[grant];
            awvalid           = up_awvalid[grant];
            wdata             = up_wdata[grant];
            wstrb             = up_wstrb[grant];
            wlast             = up_wlast[grant];
            wvalid            = up_wvalid[grant];
            bready            = up_bready[grant];
            up_awready[grant] = awready;
            up_wready[grant]  = wready;
            up_bvalid[grant]  = bvalid;
        end
    end

    // the granted bridge still waits on the response that ends the grant.
    a_read_grant_open: assert property (@(posedge aclk) disable iff (!areset)
        (state == arb_read) |-> up_rready[grant]);

    a_write_grant_open: assert property (@(posedge aclk) disable iff (!areset)
        (state == arb_write) |-> up_bready[grant]);

endmodule

// File: hw/axi_sram.sv
module axi_sram
    import cbus_pkg::*;
#(
    parameter int DEPTH_WORDS = 256
) (
    input  logic       aclk,
    input  logic       areset,
    input  addr_t      araddr,
    input  axi_len_t   arlen,
    input  axi_size_t  arsize,
    input  axi_burst_t arburst,
    input  logic       arvalid,
    output logic       arready,
    output data_t      rdata,
    output logic       rlast,
    output logic       rvalid,
    input  logic       rready,
    input  addr_t      awaddr,
    input  axi_len_t   awlen,
    input  axi_size_t  awsize,
    input  axi_burst_t awburst,
    input  logic       awvalid,
    output logic       awready,
    input  data_t      wdata,
    input  strb_t      wstrb,
    input  logic       wlast,
    input  logic       wvalid,
    output logic       wready,
    output logic       bvalid,
    input  logic       bready
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    data_t            mem [DEPTH_WORDS];
    addr_t            beat_addr;
    axi_len_t         beat_len;
    axi_len_t         remain;   // beats after the current one.
    logic             rd_active;
    logic             wr_active;
    logic             b_pend;
    logic             idle;
    logic             r_fire;
    logic             w_fire;
    logic [IDX_W-1:0] word_idx;

    assign idle     = !rd_active && !wr_active && !b_pend;
    assign arready  = idle;
    assign awready  = idle && !arvalid;   // reads win a tie.
    assign word_idx = beat_addr[IDX_W+2:3];

    assign rvalid = rd_active;
    assign rdata  = mem[word_idx];
    assign rlast  = (remain == '0);
    assign wready = wr_active;
    assign bvalid = b_pend;
    assign r_fire = rvalid && rready;
    assign w_fire = wvalid && wready;

    always_ff @(posedge aclk) begin
        if (!areset) begin
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            b_pend    <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                rd_active <= 1'b1;
            end else if (r_fire && rlast) begin
                rd_active <= 1'b0;
            end
            if (awvalid && awready) begin
                wr_active <= 1'b1;
            end else if (w_fire && wlast) begin
                wr_active <= 1'b0;
            end
            if (w_fire && wlast) begin
                b_pend <= 1'b1;   // response the cycle after the last beat.
            end else if (bready) begin
                b_pend <= 1'b0;
            end
        end
    end

    // burst address walk.
    always_ff @(posedge aclk) begin
        if (arvalid && arready) begin
            beat_addr <= araddr;
            beat_len  <= arlen;
            remain    <= arlen;
        end else if (awvalid && awready) begin
            beat_addr <= awaddr;
            beat_len  <= awlen;
            remain    <= awlen;
        end else if (r_fire || w_fire) begin
            beat_addr <= wrap_next(beat_addr, beat_len);
            remain    <= remain - axi_len_t'(1);
        end
    end

    always_ff @(posedge aclk) begin
        if (w_fire) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (wstrb[b]) begin
                    mem[word_idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    a_ar_wrap_only: assert property (@(posedge aclk) disable iff (!areset)
        arvalid |-> arburst == burst_wrap && arsize == AXI_SIZE_8B);

    a_aw_wrap_only: assert property (@(posedge aclk) disable iff (!areset)
        awvalid |-> awburst == burst_wrap && awsize == AXI_SIZE_8B);

endmodule

// File: hw/cbus_axi_top.sv
module cbus_axi_top
    import cbus_pkg::*;
#(
    parameter int NUM_PORTS   = 2,
    parameter int DEPTH_WORDS = 256
) (
    input  logic                       aclk,
    input  logic                       areset,
    input  logic      [NUM_PORTS-1:0]  creq_valid,
    input  logic      [NUM_PORTS-1:0]  creq_is_write,
    input  addr_t     [NUM_PORTS-1:0]  creq_addr,
    input  axi_size_t [NUM_PORTS-1:0]  creq_size,
    input  mlen_t     [NUM_PORTS-1:0]  creq_len,
    input  strb_t     [NUM_PORTS-1:0]  creq_strobe,
    input  data_t     [NUM_PORTS-1:0]  creq_data,
    output logic      [NUM_PORTS-1:0]  cresp_ready,
    output logic      [NUM_PORTS-1:0]  cresp_last,
    output data_t     [NUM_PORTS-1:0]  cresp_data
);

    // bridge to arbiter.
    addr_t      [NUM_PORTS-1:0] up_araddr, up_awaddr;
    axi_len_t   [NUM_PORTS-1:0] up_arlen, up_awlen;
    axi_size_t  [NUM_PORTS-1:0] up_arsize, up_awsize;
    axi_burst_t [NUM_PORTS-1:0] up_arburst, up_awburst;
    logic       [NUM_PORTS-1:0] up_arvalid, up_arready, up_awvalid, up_awready;
    data_t      [NUM_PORTS-1:0] up_rdata, up_wdata;
    logic       [NUM_PORTS-1:0] up_rlast, up_rvalid, up_rready;
    strb_t      [NUM_PORTS-1:0] up_wstrb;
    logic       [NUM_PORTS-1:0] up_wlast, up_wvalid, up_wready;
    logic       [NUM_PORTS-1:0] up_bvalid, up_bready;

    // arbiter to memory.
    addr_t      araddr, awaddr;
    axi_len_t   arlen, awlen;
    axi_size_t  arsize, awsize;
    axi_burst_t arburst, awburst;
    logic       arvalid, arready, awvalid, awready;
    data_t      rdata, wdata;
    logic       rlast, rvalid, rready;
    strb_t      wstrb;
    logic       wlast, wvalid, wready;
    logic       bvalid, bready;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_bridge
        cbus_to_axi u_bridge (
            .aclk          (aclk),
            .areset        (areset),
            .creq_valid    (creq_valid[i]),
            .creq_is_write (creq_is_write[i]),
            .creq_addr     (creq_addr[i]),
            .creq_size     (creq_size[i]),
            .creq_len      (creq_len[i]),
            .creq_strobe   (creq_strobe[i]),
            .creq_data     (creq_data[i]),
            .cresp_ready   (cresp_ready[i]),
            .cresp_last    (cresp_last[i]),
            .cresp_data    (cresp_data[i]),
            .araddr        (up_araddr[i]),
            .arlen         (up_arlen[i]),
            .arsize        (up_arsize[i]),
            .arburst       (up_arburst[i]),
            .arvalid       (up_arvalid[i]),
            .arready       (up_arready[i]),
            .rdata         (up_rdata[i]),
            .rlast         (up_rlast[i]),
            .rvalid        (up_rvalid[i]),
            .rready        (up_rready[i]),
            .awaddr        (up_awaddr[i]),
            .awlen         (up_awlen[i]),
            .awsize        (up_awsize[i]),
            .awburst       (up_awburst[i]),
            .awvalid       (up_awvalid[i]),
            .awready       (up_awready[i]),
            .wdata         (up_wdata[i]),
            .wstrb         (up_wstrb[i]),
            .wlast         (up_wlast[i]),
            .wvalid        (up_wvalid[i]),
            .wready        (up_wready[i]),
            .bvalid        (up_bvalid[i]),
            .bready        (up_bready[i])
        );
    end

    axi_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) u_arbiter (
        .aclk, .areset,
        .up_araddr, .up_arlen, .up_arsize, .up_arburst, .up_arvalid, .up_arready,
        .up_rdata, .up_rlast, .up_rvalid, .up_rready,
        .up_awaddr, .up_awlen, .up_awsize, .up_awburst, .up_awvalid, .up_awready,
        .up_wdata, .up_wstrb, .up_wlast, .up_wvalid, .up_wready,
        .up_bvalid, .up_bready,
        .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
        .rdata, .rlast, .rvalid, .rready,
        .awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
        .wdata, .wstrb, .wlast, .wvalid, .wready,
        .bvalid, .bready
    );

    axi_sram #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_sram (
        .aclk, .areset,
        .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
        .rdata, .rlast, .rvalid, .rready,
        .awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
        .wdata, .wstrb, .wlast, .wvalid, .wready,
        .bvalid, .bready
    );

endmodule

// File: testbench/tb_checker.sv
module tb_checker
    import cbus_pkg::*;
#(
    parameter int NUM_PORTS = 2
) (
    input  logic                    aclk,
    input  logic                    areset,
    input  logic  [NUM_PORTS-1:0]   creq_valid,
    input  logic  [NUM_PORTS-1:0]   creq_is_write,
    input  addr_t [NUM_PORTS-1:0]   creq_addr,
    input  mlen_t [NUM_PORTS-1:0]   creq_len,
    input  strb_t [NUM_PORTS-1:0]   creq_strobe,
    input  data_t [NUM_PORTS-1:0]   creq_data,
    input  logic  [NUM_PORTS-1:0]   cresp_ready,
    input  logic  [NUM_PORTS-1:0]   cresp_last,
    input  data_t [NUM_PORTS-1:0]   cresp_data
);

    int    data_errors = 0;
    int    protocol_errors = 0;
    int    beats_checked = 0;
    data_t model [int];          // keyed by word address.
    int    beat_cnt [NUM_PORTS];

    // word of beat k in a wrapping burst of len + 1 beats.
    function automatic int wrapped_word(addr_t start, mlen_t len, int k);
        int blk;
        int base;
        int off;
        blk  = (int'(len) + 1) * 8;
        base = int'(start) - (int'(start) % blk);
        off  = (int'(start) - base + 8 * k) % blk;
        return (base + off) / 8;
    endfunction

    function automatic data_t merge_bytes(data_t old_word, data_t fresh, strb_t strb);
        data_t result;
        result = old_word;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = fresh[b*8 +: 8];
            end
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // per-beat checks, sampled mid cycle.
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge aclk) begin
        int    word;
        data_t old_word;
        if (!areset) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                beat_cnt[p] = 0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (cresp_last[p] && !cresp_ready[p]) begin
                    protocol_errors++;
                    $display("port %0d raised cresp_last without cresp_ready at %0t", p, $time);
                end
                if (cresp_ready[p] && !creq_valid[p]) begin
                    protocol_errors++;
                    $display("port %0d gave cresp_ready with no request at %0t", p, $time);
                end
                if (cresp_ready[p]) begin
                    word = wrapped_word(creq_addr[p], creq_len[p], beat_cnt[p]);
                    beats_checked++;
                    if (creq_is_write[p]) begin
                        old_word    = model.exists(word) ? model[word] : '0;
                        model[word] = merge_bytes(old_word, creq_data[p], creq_strobe[p]);
                    end else if (!model.exists(word)) begin
                        protocol_errors++;
                        $display("port %0d read word %0d, which was never written", p, word);
                    end else if (cresp_data[p] !== model[word]) begin
                        data_errors++;
                        $display("FAIL t=%0t cresp_data[%0d] expected %h got %h",
                                 $time, p, model[word], cresp_data[p]);
                    end
                    if (cresp_last[p]) begin
                        if (beat_cnt[p] != int'(creq_len[p])) begin
                            protocol_errors++;
                            $display("port %0d burst ended after %0d beats instead of %0d",
                                     p, beat_cnt[p] + 1, int'(creq_len[p]) + 1);
                        end
                        beat_cnt[p] = 0;
                    end else begin
                        if (beat_cnt[p] == int'(creq_len[p])) begin
                            protocol_errors++;
                            $display("port %0d final beat %0d came without cresp_last",
                                     p, beat_cnt[p] + 1);
                        end
                        beat_cnt[p] = beat_cnt[p] + 1;
                    end
                end
            end
        end
    end

endmodule

// File: testbench/tb_top.sv
module tb_top
    import cbus_pkg::*;
();

    localparam int NUM_PORTS   = 2;
    localparam int DEPTH_WORDS = 256;
    localparam int NUM_ROWS    = 13;
    localparam int CLK_HALF    = 20;

    // one row of stimulus, applied to every port set in port_mask.
    typedef struct packed {
        logic  [NUM_PORTS-1:0] port_mask;
        logic  [NUM_PORTS-1:0] write_mask;
        addr_t [NUM_PORTS-1:0] addr;
        mlen_t                 len;
        strb_t                 strobe;
        logic                  use_lfsr;    // else fixed_data plus beat index.
        data_t                 fixed_data;
    } stim_row_t;

    logic                       aclk = 1'b0;
    logic                       areset;
    logic      [NUM_PORTS-1:0]  creq_valid;
    logic      [NUM_PORTS-1:0]  creq_is_write;
    addr_t     [NUM_PORTS-1:0]  creq_addr;
    axi_size_t [NUM_PORTS-1:0]  creq_size;
    mlen_t     [NUM_PORTS-1:0]  creq_len;
    strb_t     [NUM_PORTS-1:0]  creq_strobe;
    data_t     [NUM_PORTS-1:0]  creq_data;
    logic      [NUM_PORTS-1:0]  cresp_ready;
    logic      [NUM_PORTS-1:0]  cresp_last;
    data_t     [NUM_PORTS-1:0]  cresp_data;

    stim_row_t   stim [NUM_ROWS];
    logic [31:0] lfsr_state = 32'heced_9fcb;
    int          cycles = 0;
    int          cycle_limit;
    int          timeouts = 0;

    always #CLK_HALF aclk = ~aclk;

    cbus_axi_top #(
        .NUM_PORTS   (NUM_PORTS),
        .DEPTH_WORDS (DEPTH_WORDS)
    ) UUT (
        .aclk, .areset,
        .creq_valid, .creq_is_write, .creq_addr, .creq_size, .creq_len,
        .creq_strobe, .creq_data,
        .cresp_ready, .cresp_last, .cresp_data
    );

    tb_checker #(
        .NUM_PORTS (NUM_PORTS)
    ) u_check (
        .aclk, .areset,
        .creq_valid, .creq_is_write, .creq_addr, .creq_len,
        .creq_strobe, .creq_data,
        .cresp_ready, .cresp_last, .cresp_data
    );

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table.
    ////////////////////////////////////////////////////////////////////////////

    function automatic stim_row_t make_row(logic [NUM_PORTS-1:0] port_mask,
            logic [NUM_PORTS-1:0] write_mask, addr_t addr0, addr_t addr1,
            mlen_t len, strb_t strobe, logic use_lfsr, data_t fixed_data);
        stim_row_t row;
        row.port_mask  = port_mask;
        row.write_mask = write_mask;
        row.addr[0]    = addr0;
        row.addr[1]    = addr1;
        row.len        = len;
        row.strobe     = strobe;
        row.use_lfsr   = use_lfsr;
        row.fixed_data = fixed_data;
        return row;
    endfunction

    task automatic load_table();
        stim[0]  = make_row(2'b01, 2'b01, 32'h000, 32'h000, 4'd0, 8'hff, 1'b0,
                            64'h1111_2222_3333_4444);   // single beat write.
        stim[1]  = make_row(2'b01, 2'b00, 32'h000, 32'h000, 4'd0, 8'hff, 1'b0, '0);
        stim[2]  = make_row(2'b10, 2'b10, 32'h000, 32'h040, 4'd3, 8'hff, 1'b1, '0);
        stim[3]  = make_row(2'b10, 2'b00, 32'h000, 32'h050, 4'd3, 8'hff, 1'b0, '0);
        stim[4]  = make_row(2'b01, 2'b01, 32'h048, 32'h000, 4'd0, 8'h0f, 1'b0,
                            64'haaaa_bbbb_cccc_dddd);   // low half only.
        stim[5]  = make_row(2'b01, 2'b00, 32'h040, 32'h000, 4'd3, 8'hff, 1'b0, '0);
        stim[6]  = make_row(2'b10, 2'b10, 32'h000, 32'h080, 4'd1, 8'hff, 1'b1, '0);
        stim[7]  = make_row(2'b11, 2'b10, 32'h088, 32'h0c0, 4'd1, 8'hff, 1'b1, '0);
        stim[8]  = make_row(2'b01, 2'b00, 32'h0c8, 32'h000, 4'd1, 8'hff, 1'b0, '0);
        stim[9]  = make_row(2'b11, 2'b11, 32'h100, 32'h1a0, 4'd15, 8'hff, 1'b1, '0);
        stim[10] = make_row(2'b11, 2'b00, 32'h140, 32'h180, 4'd15, 8'hff, 1'b0, '0);
        stim[11] = make_row(2'b11, 2'b01, 32'h200, 32'h130, 4'd15, 8'hff, 1'b1, '0);
        stim[12] = make_row(2'b10, 2'b00, 32'h000, 32'h270, 4'd15, 8'hff, 1'b0, '0);
    endtask

    // each row may take up to len + 11 cycles per port.
    function automatic int limit_from_table();
        int total;
        total = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += (int'(stim[r].len) + 1 + 10) * NUM_PORTS;
        end
        return total;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // data generation.
    ////////////////////////////////////////////////////////////////////////////

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_beat(output data_t beat);
        beat = '0;
        for (int b = 0; b < DATA_WIDTH; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            beat = {beat[DATA_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    task automatic beat_value(input stim_row_t row, input int k, output data_t beat);
        if (row.use_lfsr) begin
            random_beat(beat);
        end else begin
            beat = row.fixed_data + data_t'(k);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // driving loop.
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_row(input stim_row_t row);
        logic [NUM_PORTS-1:0] done;
        logic [NUM_PORTS-1:0] seen_ready;
        logic [NUM_PORTS-1:0] seen_last;
        int                   beat_idx [NUM_PORTS];
        data_t                value;
        done = ~row.port_mask;
        for (int p = 0; p < NUM_PORTS; p++) begin
            beat_idx[p] = 0;
            if (row.port_mask[p]) begin
                creq_is_write[p] = row.write_mask[p];
                creq_addr[p]     = row.addr[p];
                creq_size[p]     = AXI_SIZE_8B;
                creq_len[p]      = row.len;
                creq_strobe[p]   = row.strobe;
                creq_data[p]     = '0;
                if (row.write_mask[p]) begin
                    beat_value(row, 0, value);
                    creq_data[p] = value;
                end
                creq_valid[p] = 1'b1;
            end
        end
        while (done != '1) begin
            @(negedge aclk);              // responses settled mid cycle.
            seen_ready = cresp_ready;
            seen_last  = cresp_last;
            @(posedge aclk);
            #1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!done[p] && seen_last[p]) begin
                    creq_valid[p] = 1'b0;
                    done[p]       = 1'b1;
                end else if (!done[p] && seen_ready[p] && row.write_mask[p]) begin
                    beat_idx[p] = beat_idx[p] + 1;
                    beat_value(row, beat_idx[p], value);
                    creq_data[p] = value;
                end
            end
        end
        @(posedge aclk);                  // valid stays low for one edge.
        #1;
    endtask

    task automatic report_counts();
        $display("errors: data %0d, protocol %0d, timeout %0d (%0d beats checked)",
                 u_check.data_errors, u_check.protocol_errors, timeouts,
                 u_check.beats_checked);
    endtask

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            timeouts = timeouts + 1;
            $display("timeout: stimulus did not finish within %0d cycles", cycle_limit);
            report_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        areset        = 1'b0;
        creq_valid    = '0;
        creq_is_write = '0;
        creq_addr     = '0;
        creq_size     = '0;
        creq_len      = '0;
        creq_strobe   = '0;
        creq_data     = '0;
        load_table();
        cycle_limit = limit_from_table();
        repeat (5) @(posedge aclk);
        #1;
        areset = 1'b1;
        repeat (4) @(posedge aclk);       // idle ports, no response expected.
        #1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(stim[r]);
        end
        repeat (2) @(posedge aclk);
        report_counts();
        if (u_check.data_errors + u_check.protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
hw/cbus_pkg.sv
hw/cbus_to_axi.sv
hw/axi_arbiter.sv
hw/axi_sram.sv
hw/cbus_axi_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the cache bus to AXI testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
